// File: Makefile
# Verilator flow for the Sv32 MMU and its testbench

.PHONY: lint sim clean

# Lint the RTL top on its own
lint:
	verilator --lint-only --timing -f list.f --top-module mmu

# Build and run the testbench, the log decides pass or fail
sim:
	verilator --binary --timing -f list.f --top-module mmuTb -o mmuTb
	./obj_dir/mmuTb | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log

// File: list.f
+incdir+src
+incdir+test
src/mmuPkg.sv
src/tlb.sv
src/pmaChecker.sv
src/pmpChecker.sv
src/mmu.sv
test/mmuTb.sv

// File: src/mmu.sv
// MMU top: picks bare or Sv32 addressing and gates TLB, PMA and PMP results into the outputs
`include "mmu_macros.svh"

module mmu import mmuPkg::*; #(
  parameter int ENTRY_BITS = `TLB_ENTRY_BITS,
  parameter int IMMU = 0
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [`XLEN-1:0]             satp,
  input  logic                         statusMxr,
  input  logic                         statusSum,
  input  privModeT                     privMode,
  input  accessTypeT                   accessType,
  input  logic [`XLEN-1:0]             virtualAddress,
  input  logic [`XLEN-1:0]             pteWriteVal,
  input  pageTypeT                     pageTypeWriteVal,
  input  logic                         tlbWrite,
  input  logic                         tlbFlush,
  input  logic [`PMP_ENTRIES*8-1:0]    pmpCfg,
  input  logic [`PMP_ENTRIES*`XLEN-1:0] pmpAddr,
  output logic [`PA_BITS-1:0]          physicalAddress,
  output logic                         tlbHit,
  output logic                         tlbMiss,
  output logic                         tlbPageFault,
  output logic                         pmaFault,
  output logic                         pmpFault,
  output logic                         squashBusAccess,
  output logic [`REGION_COUNT-1:0]     regionSel
);

  logic [`PA_BITS-1:0] translatedAddress;
  logic                tlbHitRaw;
  logic                pageFaultRaw;
  logic                pmaFaultRaw;
  logic                pmpFaultRaw;
  logic                translating;
  logic                accessValid;
  logic                checksValid;

  // Sv32 applies outside machine mode when satp.MODE is set
  assign translating = satp[`XLEN-1] && (privMode != machine);
  assign accessValid = |accessType;

  tlb #(.ENTRY_BITS(ENTRY_BITS), .INSTR(IMMU)) u_tlb (
    .clk(clk), .rst(rst), .virtualAddress(virtualAddress), .accessType(accessType),
    .privMode(privMode), .statusMxr(statusMxr), .statusSum(statusSum),
    .pteWriteVal(pteWriteVal), .pageTypeWriteVal(pageTypeWriteVal), .tlbWrite(tlbWrite),
    .tlbFlush(tlbFlush), .translatedAddress(translatedAddress), .tlbHitRaw(tlbHitRaw),
    .pageFaultRaw(pageFaultRaw)
  );

  // Bare mode zero-extends the virtual address
  assign physicalAddress = translating ? translatedAddress : {2'b00, virtualAddress};

  //////////////////////////////////////////////////
  // Physical checks
  //////////////////////////////////////////////////

  pmaChecker u_pmaChecker (
    .physicalAddress(physicalAddress), .accessType(accessType),
    .regionSel(regionSel), .pmaFaultRaw(pmaFaultRaw)
  );

  pmpChecker u_pmpChecker (
    .physicalAddress(physicalAddress), .accessType(accessType), .privMode(privMode),
    .pmpCfg(pmpCfg), .pmpAddr(pmpAddr), .pmpFaultRaw(pmpFaultRaw)
  );

  // Only a real access with a usable physical address is checked
  assign checksValid = accessValid && (!translating || (tlbHitRaw && !pageFaultRaw));

  assign tlbHit = translating && accessValid && tlbHitRaw;
  assign tlbMiss = translating && accessValid && !tlbHitRaw;
  assign tlbPageFault = translating && accessValid && pageFaultRaw;
  assign pmaFault = pmaFaultRaw && checksValid;
  assign pmpFault = pmpFaultRaw && checksValid;

  // Either access fault stops the bus cycle
  assign squashBusAccess = pmaFault || pmpFault;

endmodule

// File: src/mmuPkg.sv
// Common types for the MMU blocks, imported by each module that uses them
package mmuPkg;

  // Privilege encodings as in the mstatus MPP field
  typedef enum logic [1:0] {
    user       = 2'd0,
    supervisor = 2'd1,
    machine    = 2'd3
  } privModeT;

  // Page size of a TLB entry
  typedef enum logic {
    kilopage = 1'b0,
    megapage = 1'b1
  } pageTypeT;

  // Bit 1 read or fetch, bit 0 write, zero means idle
  typedef logic [1:0] accessTypeT;

  // PMP address matching modes
  typedef enum logic [1:0] {
    off   = 2'd0,
    tor   = 2'd1,
    na4   = 2'd2,
    napot = 2'd3
  } pmpModeT;

  // One pmpcfg byte, msb first
  typedef struct packed {
    logic       lock;
    logic [1:0] reserved;
    pmpModeT    addressMode;
    logic       x;
    logic       w;
    logic       r;
  } pmpCfgT;

endpackage

// File: src/mmu_macros.svh
// Shared widths, table sizes and region bounds for the MMU, included by every file that needs them
`ifndef MMU_MACROS_SVH
`define MMU_MACROS_SVH

// Datapath widths for Sv32
`define XLEN 32
`define PA_BITS 34

// Table sizes
`define PMP_ENTRIES 4
`define TLB_ENTRY_BITS 3

// Fixed physical regions, inclusive bounds
`define ROM_BASE 34'h0_0000_1000
`define ROM_END 34'h0_0000_1FFF
`define RAM_BASE 34'h0_8000_0000
`define RAM_END 34'h0_8FFF_FFFF
`define UART_BASE 34'h0_1000_0000
`define UART_END 34'h0_1000_0FFF
`define TIMER_BASE 34'h0_0200_0000
`define TIMER_END 34'h0_0200_FFFF
`define REGION_COUNT 4

`endif

// File: src/pmaChecker.sv
// Physical memory attribute check, decodes the physical address into fixed regions
`include "mmu_macros.svh"

module pmaChecker import mmuPkg::*; (
  input  logic [`PA_BITS-1:0]      physicalAddress,
  input  accessTypeT               accessType,
  output logic [`REGION_COUNT-1:0] regionSel,
  output logic                     pmaFaultRaw
);

  logic inRom;
  logic inRam;
  logic inUart;
  logic inTimer;
  logic noRegion;
  logic romWrite;

  //////////////////////////////////////////////////
  // Region decode
  //////////////////////////////////////////////////

  // Inclusive bounds, regions do not overlap
  assign inRom = (physicalAddress >= `ROM_BASE) && (physicalAddress <= `ROM_END);
  assign inRam = (physicalAddress >= `RAM_BASE) && (physicalAddress <= `RAM_END);
  assign inUart = (physicalAddress >= `UART_BASE) && (physicalAddress <= `UART_END);
  assign inTimer = (physicalAddress >= `TIMER_BASE) && (physicalAddress <= `TIMER_END);

  // One-hot select
  // bit 0 ROM, bit 1 RAM, bit 2 UART, bit 3 timer
  assign regionSel = {inTimer, inUart, inRam, inRom};

  //////////////////////////////////////////////////
  // Attribute check
  //////////////////////////////////////////////////

  // Unmapped space is never accessible
  assign noRegion = ~|regionSel;

  // Boot ROM is read only
  assign romWrite = inRom && accessType[0];

  assign pmaFaultRaw = noRegion || romWrite;

endmodule

// File: src/pmpChecker.sv
// Physical memory protection over four entries, lowest matching entry decides the access
`include "mmu_macros.svh"

module pmpChecker import mmuPkg::*; (
  input  logic [`PA_BITS-1:0]          physicalAddress,
  input  accessTypeT                   accessType,
  input  privModeT                     privMode,
  input  logic [`PMP_ENTRIES*8-1:0]    pmpCfg,
  input  logic [`PMP_ENTRIES*`XLEN-1:0] pmpAddr,
  output logic                         pmpFaultRaw
);

  pmpCfgT                 cfg [`PMP_ENTRIES];
  logic [`XLEN-1:0]       addr [`PMP_ENTRIES];
  logic [`XLEN-1:0]       paWord;
  logic [`PMP_ENTRIES-1:0] entryMatch;
  logic                   anyMatch;
  pmpCfgT                 winCfg;
  logic                   isMachine;
  logic                   permFault;

  // Unpack the flat CSR images
  always_comb begin
    for (int i = 0; i < `PMP_ENTRIES; i++) begin
      cfg[i] = pmpCfgT'(pmpCfg[8*i +: 8]);
      addr[i] = pmpAddr[`XLEN*i +: `XLEN];
    end
  end

  // pmpaddr holds bits 33:2, compare in the same units
  assign paWord = physicalAddress[`PA_BITS-1:2];

  //////////////////////////////////////////////////
  // Per-entry match
  //////////////////////////////////////////////////

  for (genvar i = 0; i < `PMP_ENTRIES; i++) begin : gEntry
    logic [`XLEN-1:0] lowBound;
    logic [`XLEN-1:0] napotCare;

    // TOR range starts at the previous entry
    if (i == 0) begin : gFirst
      assign lowBound = '0;
    end else begin : gRest
      assign lowBound = addr[i-1];
    end

    // Trailing ones plus the first zero are don't-care bits
    assign napotCare = ~(addr[i] ^ (addr[i] + `XLEN'(1)));

    // NA4 is handled as OFF
    always_comb begin
      case (cfg[i].addressMode)
        tor:     entryMatch[i] = (paWord >= lowBound) && (paWord < addr[i]);
        napot:   entryMatch[i] = ((paWord ^ addr[i]) & napotCare) == '0;
        default: entryMatch[i] = 1'b0;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Priority and permission
  //////////////////////////////////////////////////

  // Lowest numbered match wins
  always_comb begin
    anyMatch = 1'b0;
    winCfg = '0;
    for (int i = `PMP_ENTRIES - 1; i >= 0; i--) begin
      if (entryMatch[i]) begin
        anyMatch = 1'b1;
        winCfg = cfg[i];
      end
    end
  end

  assign isMachine = (privMode == machine);
  assign permFault = (accessType[1] && !winCfg.r) || (accessType[0] && !winCfg.w);

  // Machine mode only bound by locked entries, no match passes machine only
  assign pmpFaultRaw = anyMatch ? ((!isMachine || winCfg.lock) && permFault) : !isMachine;

endmodule

// File: src/tlb.sv
// Fully associative Sv32 TLB with combinational lookup and checks, refilled and flushed by strobes
`include "mmu_macros.svh"

module tlb import mmuPkg::*; #(
  parameter int ENTRY_BITS = `TLB_ENTRY_BITS,
  parameter int INSTR = 0
) (
  input  logic                clk,
  input  logic                rst,
  input  logic [`XLEN-1:0]    virtualAddress,
  input  accessTypeT          accessType,
  input  privModeT            privMode,
  input  logic                statusMxr,
  input  logic                statusSum,
  input  logic [`XLEN-1:0]    pteWriteVal,
  input  pageTypeT            pageTypeWriteVal,
  input  logic                tlbWrite,
  input  logic                tlbFlush,
  output logic [`PA_BITS-1:0] translatedAddress,
  output logic                tlbHitRaw,
  output logic                pageFaultRaw
);

  localparam int ENTRIES = 2 ** ENTRY_BITS;
  localparam int VPN_BITS = `XLEN - 12;
  localparam int PPN_BITS = `PA_BITS - 12;
  localparam logic IS_INSTR = (INSTR != 0);

  // Entry storage
  logic [ENTRIES-1:0]    entryValid;
  logic [VPN_BITS-1:0]   entryVpn [ENTRIES];
  logic [PPN_BITS-1:0]   entryPpn [ENTRIES];
  // Kept flags as {D, A, U, X, W, R}
  logic [5:0]            entryFlags [ENTRIES];
  pageTypeT              entryType [ENTRIES];
  logic [ENTRY_BITS-1:0] victimPtr;

  // Lookup results
  logic [VPN_BITS-1:0]   vaVpn;
  logic [ENTRIES-1:0]    entryMatch;
  logic [ENTRY_BITS-1:0] hitIdx;
  logic [PPN_BITS-1:0]   hitPpn;
  logic [5:0]            hitFlags;
  pageTypeT              hitType;

  // Permission terms
  logic isRead;
  logic isWrite;
  logic readOk;
  logic userFault;
  logic readFault;
  logic writeFault;
  logic adFault;

  //////////////////////////////////////////////////
  // Refill and flush
  //////////////////////////////////////////////////

  // Valid bits and victim pointer; flush wins over a write
  always_ff @(posedge clk) begin
    if (rst) begin
      entryValid <= '0;
      victimPtr <= '0;
    end else if (tlbFlush) begin
      entryValid <= '0;
    end else if (tlbWrite) begin
      entryValid[victimPtr] <= 1'b1;
      // Round-robin, wraps at the table size
      victimPtr <= victimPtr + 1'b1;
    end
  end

  // Payload fields of the victim entry
  always_ff @(posedge clk) begin
    if (tlbWrite && !tlbFlush) begin
      entryVpn[victimPtr] <= virtualAddress[`XLEN-1:12];
      entryPpn[victimPtr] <= pteWriteVal[31:10];
      entryFlags[victimPtr] <= {pteWriteVal[7:6], pteWriteVal[4:1]};
      entryType[victimPtr] <= pageTypeWriteVal;
    end
  end

  //////////////////////////////////////////////////
  // Lookup
  //////////////////////////////////////////////////

  assign vaVpn = virtualAddress[`XLEN-1:12];

  // Megapages ignore VPN0
  always_comb begin
    for (int i = 0; i < ENTRIES; i++) begin
      entryMatch[i] = entryValid[i]
                    && (entryVpn[i][VPN_BITS-1:10] == vaVpn[VPN_BITS-1:10])
                    && ((entryType[i] == megapage) || (entryVpn[i][9:0] == vaVpn[9:0]));
    end
  end

  // Lowest index wins if two entries alias
  always_comb begin
    hitIdx = '0;
    tlbHitRaw = 1'b0;
    for (int i = ENTRIES - 1; i >= 0; i--) begin
      if (entryMatch[i]) begin
        hitIdx = ENTRY_BITS'(i);
        tlbHitRaw = 1'b1;
      end
    end
  end

  assign hitPpn = entryPpn[hitIdx];
  assign hitFlags = entryFlags[hitIdx];
  assign hitType = entryType[hitIdx];

  // Megapage passes VPN0 straight into the physical address
  assign translatedAddress = (hitType == megapage) ?
                             {hitPpn[PPN_BITS-1:10], virtualAddress[21:0]} :
                             {hitPpn, virtualAddress[11:0]};

  //////////////////////////////////////////////////
  // Permission check
  //////////////////////////////////////////////////

  assign isRead = accessType[1];
  assign isWrite = accessType[0];

  // Fetch side checks X, data side allows X under MXR
  assign readOk = IS_INSTR ? hitFlags[2] : (hitFlags[0] | (statusMxr & hitFlags[2]));

  assign userFault = ((privMode == supervisor) && hitFlags[3] && !statusSum)
                   || ((privMode == user) && !hitFlags[3]);
  assign readFault = isRead && !readOk;
  assign writeFault = isWrite && !hitFlags[1];
  // No A/D update here, so a missing bit is a fault
  assign adFault = !hitFlags[4] || (isWrite && !hitFlags[5]);

  assign pageFaultRaw = tlbHitRaw && (userFault || readFault || writeFault || adFault);

endmodule

// File: test/mmuTests.svh
// Directed MMU tests, included into the testbench module body

// Random addresses leave the MMU untranslated even when the TLB holds them
task automatic runBareMode();
  int          errorsBefore;
  logic [31:0] va;
  errorsBefore = errorCount;
  for (int i = 0; i < 16; i++) begin
    takeBits(32, va);
    // Matching entry whose target differs from the bare address
    writeEntry(va, makePte(22'h3F_FFFF, 8'hC7), kilopage);
    // Machine mode ignores satp, supervisor needs satp clear
    if (i < 8) begin
      driveAccess(1'b1, machine, 2'b10, va, 1'b0, 1'b0);
    end else begin
      driveAccess(1'b0, supervisor, 2'b10, va, 1'b0, 1'b0);
    end
    checkValue("bare physicalAddress", physicalAddress, {2'b00, va});
    checkBit("bare tlbHit", tlbHit, 1'b0);
    checkBit("bare tlbMiss", tlbMiss, 1'b0);
  end
  flushTlb();
  finishTest("bare mode", errorsBefore);
endtask

task automatic runMissRefillFlush();
  int          errorsBefore;
  logic [21:0] kiloPpn;
  logic [21:0] megaPpn;
  errorsBefore = errorCount;
  kiloPpn = 22'h08_0123;
  megaPpn = 22'h00_2000;
  // Table is empty after reset
  driveAccess(1'b1, supervisor, 2'b10, 32'h0040_1234, 1'b0, 1'b0);
  checkBit("miss after reset", tlbMiss, 1'b1);
  checkBit("hit after reset", tlbHit, 1'b0);
  // Flags D A W R V
  writeEntry(32'h0040_1000, makePte(kiloPpn, 8'hC7), kilopage);
  driveAccess(1'b1, supervisor, 2'b10, 32'h0040_1ABC, 1'b0, 1'b0);
  checkBit("kilopage hit", tlbHit, 1'b1);
  checkValue("kilopage address", physicalAddress, {kiloPpn, 12'hABC});
  // Any VPN0 under VPN1 0x030 hits
  writeEntry(32'h0C00_0000, makePte(megaPpn, 8'hC7), megapage);
  driveAccess(1'b1, supervisor, 2'b10, 32'h0C12_3456, 1'b0, 1'b0);
  checkBit("megapage hit", tlbHit, 1'b1);
  checkValue("megapage address", physicalAddress, {megaPpn[21:10], 22'h12_3456});
  flushTlb();
  driveAccess(1'b1, supervisor, 2'b10, 32'h0040_1ABC, 1'b0, 1'b0);
  checkBit("kilopage miss after flush", tlbMiss, 1'b1);
  driveAccess(1'b1, supervisor, 2'b10, 32'h0C12_3456, 1'b0, 1'b0);
  checkBit("megapage miss after flush", tlbMiss, 1'b1);
  // Nine refills into eight entries drop the oldest
  for (int i = 0; i < 9; i++) begin
    writeEntry(32'h1000_0000 + 32'(i) * 32'h1000, makePte(22'h08_0000 + 22'(i), 8'hC7),
               kilopage);
  end
  driveAccess(1'b1, supervisor, 2'b10, 32'h1000_0010, 1'b0, 1'b0);
  checkBit("oldest entry evicted", tlbMiss, 1'b1);
  driveAccess(1'b1, supervisor, 2'b10, 32'h1000_1010, 1'b0, 1'b0);
  checkBit("second entry kept", tlbHit, 1'b1);
  driveAccess(1'b1, supervisor, 2'b10, 32'h1000_8010, 1'b0, 1'b0);
  checkBit("newest entry hit", tlbHit, 1'b1);
  checkValue("newest entry address", physicalAddress, {22'h08_0008, 12'h010});
  finishTest("miss refill flush", errorsBefore);
endtask

task automatic runPageFaults();
  int errorsBefore;
  errorsBefore = errorCount;
  // D A R V without W
  writeEntry(32'h2000_0000, makePte(22'h08_0000, 8'hC3), kilopage);
  // D A U W R V
  writeEntry(32'h2000_1000, makePte(22'h08_0001, 8'hD7), kilopage);
  // D A X V for an execute-only page
  writeEntry(32'h2000_2000, makePte(22'h08_0002, 8'hC9), kilopage);
  // D W R V with A clear
  writeEntry(32'h2000_3000, makePte(22'h08_0003, 8'h87), kilopage);
  driveAccess(1'b1, supervisor, 2'b01, 32'h2000_0004, 1'b0, 1'b0);
  checkBit("write without W", tlbPageFault, 1'b1);
  driveAccess(1'b1, supervisor, 2'b10, 32'h2000_0004, 1'b0, 1'b0);
  checkBit("read with R", tlbPageFault, 1'b0);
  driveAccess(1'b1, supervisor, 2'b10, 32'h2000_1004, 1'b0, 1'b0);
  checkBit("U page, SUM clear", tlbPageFault, 1'b1);
  driveAccess(1'b1, supervisor, 2'b10, 32'h2000_1004, 1'b0, 1'b1);
  checkBit("U page, SUM set", tlbPageFault, 1'b0);
  driveAccess(1'b1, supervisor, 2'b10, 32'h2000_2004, 1'b0, 1'b0);
  checkBit("X-only read, MXR clear", tlbPageFault, 1'b1);
  driveAccess(1'b1, supervisor, 2'b10, 32'h2000_2004, 1'b1, 1'b0);
  checkBit("X-only read, MXR set", tlbPageFault, 1'b0);
  driveAccess(1'b1, supervisor, 2'b10, 32'h2000_3004, 1'b0, 1'b0);
  checkBit("A clear", tlbPageFault, 1'b1);
  finishTest("page faults", errorsBefore);
endtask

task automatic runPmaRegions();
  int errorsBefore;
  errorsBefore = errorCount;
  // Bare machine mode with no PMP entries so only PMA can squash
  driveAccess(1'b0, machine, 2'b10, 32'h0000_1800, 1'b0, 1'b0);
  checkValue("ROM regionSel", {30'd0, regionSel}, 34'h1);
  checkBit("ROM read pmaFault", pmaFault, 1'b0);
  driveAccess(1'b0, machine, 2'b11, 32'h8123_4560, 1'b0, 1'b0);
  checkValue("RAM regionSel", {30'd0, regionSel}, 34'h2);
  checkBit("RAM pmaFault", pmaFault, 1'b0);
  driveAccess(1'b0, machine, 2'b11, 32'h1000_0010, 1'b0, 1'b0);
  checkValue("UART regionSel", {30'd0, regionSel}, 34'h4);
  checkBit("UART pmaFault", pmaFault, 1'b0);
  driveAccess(1'b0, machine, 2'b11, 32'h0200_4000, 1'b0, 1'b0);
  checkValue("timer regionSel", {30'd0, regionSel}, 34'h8);
  checkBit("timer pmaFault", pmaFault, 1'b0);
  driveAccess(1'b0, machine, 2'b10, 32'h4000_0000, 1'b0, 1'b0);
  checkBit("unmapped pmaFault", pmaFault, 1'b1);
  checkBit("unmapped squash", squashBusAccess, 1'b1);
  driveAccess(1'b0, machine, 2'b01, 32'h0000_1000, 1'b0, 1'b0);
  checkBit("ROM write pmaFault", pmaFault, 1'b1);
  checkBit("ROM write squash", squashBusAccess, 1'b1);
  // Every entry targets unmapped space so a miss sees a faulting address
  for (int i = 0; i < 8; i++) begin
    writeEntry(32'h3000_0000 + 32'(i) * 32'h1000, makePte(22'h04_0000 + 22'(i), 8'hC7),
               kilopage);
  end
  // No entry maps this VPN
  driveAccess(1'b1, supervisor, 2'b10, 32'h7000_0000, 1'b0, 1'b0);
  checkBit("miss reported", tlbMiss, 1'b1);
  checkBit("miss pmaFault", pmaFault, 1'b0);
  finishTest("PMA regions", errorsBefore);
endtask

task automatic runPmpEntries();
  int          errorsBefore;
  logic [31:0] ramNapot;
  logic [31:0] uartNapot;
  errorsBefore = errorCount;
  // NAPOT image is base/4 with size/8-1 ones below it
  ramNapot = (32'h8000_0000 >> 2) | ((32'h1000_0000 >> 3) - 1);
  uartNapot = (32'h1000_0000 >> 2) | ((32'h0000_1000 >> 3) - 1);
  // 0 OFF base, 1 TOR R over timer, 2 NAPOT RW over RAM, 3 locked NAPOT R over UART
  @(posedge clk);
  pmpCfg <= {8'h99, 8'h1B, 8'h09, 8'h00};
  pmpAddr <= {uartNapot, ramNapot, 32'h0080_4000, 32'h0080_0000};
  driveAccess(1'b0, supervisor, 2'b10, 32'h0200_4000, 1'b0, 1'b0);
  checkBit("TOR read", pmpFault, 1'b0);
  driveAccess(1'b0, supervisor, 2'b01, 32'h0200_4000, 1'b0, 1'b0);
  checkBit("TOR write", pmpFault, 1'b1);
  checkBit("TOR write squash", squashBusAccess, 1'b1);
  driveAccess(1'b0, supervisor, 2'b11, 32'h8800_0000, 1'b0, 1'b0);
  checkBit("NAPOT RAM access", pmpFault, 1'b0);
  checkBit("NAPOT RAM squash", squashBusAccess, 1'b0);
  driveAccess(1'b0, supervisor, 2'b10, 32'h0000_1800, 1'b0, 1'b0);
  checkBit("no match, supervisor", pmpFault, 1'b1);
  driveAccess(1'b0, machine, 2'b10, 32'h0000_1800, 1'b0, 1'b0);
  checkBit("no match, machine", pmpFault, 1'b0);
  driveAccess(1'b0, machine, 2'b10, 32'h1000_0010, 1'b0, 1'b0);
  checkBit("locked read, machine", pmpFault, 1'b0);
  driveAccess(1'b0, machine, 2'b01, 32'h1000_0010, 1'b0, 1'b0);
  checkBit("locked write, machine", pmpFault, 1'b1);
  finishTest("PMP entries", errorsBefore);
endtask

// File: test/mmuTb.sv
// Testbench top for the MMU, owns clock, reset, DUT and helpers and runs the included tests
`include "mmu_macros.svh"

module mmuTb import mmuPkg::*; ();

  localparam int TIMEOUT_CYCLES = 2000;

  // DUT inputs
  logic                          clk;
  logic                          rst;
  logic [`XLEN-1:0]              satp;
  logic                          statusMxr;
  logic                          statusSum;
  privModeT                      privMode;
  accessTypeT                    accessType;
  logic [`XLEN-1:0]              virtualAddress;
  logic [`XLEN-1:0]              pteWriteVal;
  pageTypeT                      pageTypeWriteVal;
  logic                          tlbWrite;
  logic                          tlbFlush;
  logic [`PMP_ENTRIES*8-1:0]     pmpCfg;
  logic [`PMP_ENTRIES*`XLEN-1:0] pmpAddr;

  // DUT outputs
  logic [`PA_BITS-1:0]           physicalAddress;
  logic                          tlbHit;
  logic                          tlbMiss;
  logic                          tlbPageFault;
  logic                          pmaFault;
  logic                          pmpFault;
  logic                          squashBusAccess;
  logic [`REGION_COUNT-1:0]      regionSel;

  // Bookkeeping
  int          errorCount;
  int          testsPassed;
  int          testsFailed;
  int          cycleCount;
  logic [15:0] lfsrState;

  mmu u_mmu (
    .clk(clk), .rst(rst), .satp(satp), .statusMxr(statusMxr), .statusSum(statusSum),
    .privMode(privMode), .accessType(accessType), .virtualAddress(virtualAddress),
    .pteWriteVal(pteWriteVal), .pageTypeWriteVal(pageTypeWriteVal), .tlbWrite(tlbWrite),
    .tlbFlush(tlbFlush), .pmpCfg(pmpCfg), .pmpAddr(pmpAddr),
    .physicalAddress(physicalAddress), .tlbHit(tlbHit), .tlbMiss(tlbMiss),
    .tlbPageFault(tlbPageFault), .pmaFault(pmaFault), .pmpFault(pmpFault),
    .squashBusAccess(squashBusAccess), .regionSel(regionSel)
  );

  //////////////////////////////////////////////////
  // Clock and watchdog
  //////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Runs far past the few hundred cycles the tests need
  initial begin
    cycleCount = 0;
    while (cycleCount < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("Timeout: the tests were still running after %0d cycles", TIMEOUT_CYCLES);
    $display("Test failures found");
    $finish;
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  // 16-bit Galois LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsrNext(input logic [15:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 16'hB400;
    end
    return state >> 1;
  endfunction

  // One LFSR step per bit
  task automatic takeBits(input int count, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsrState = lfsrNext(lfsrState);
      value = {value[30:0], lfsrState[0]};
    end
  endtask

  task automatic checkBit(input string what, input logic got, input logic expected);
    if (got !== expected) begin
      $display("error at time %0t: %s is %b, expected %b", $time, what, got, expected);
      errorCount++;
    end
  endtask

  task automatic checkValue(input string what, input logic [33:0] got,
                            input logic [33:0] expected);
    if (got !== expected) begin
      $display("error at time %0t: %s is %h, expected %h", $time, what, got, expected);
      errorCount++;
    end
  endtask

  task automatic finishTest(input string name, input int errorsBefore);
    if (errorCount == errorsBefore) begin
      testsPassed++;
      $display("test %s: ok", name);
    end else begin
      testsFailed++;
      $display("test %s: FAILED with %0d errors", name, errorCount - errorsBefore);
    end
  endtask

  // Sv32 PTE image with the PPN above two RSW bits and the flag byte
  function automatic logic [31:0] makePte(input logic [21:0] ppn, input logic [7:0] flags);
    return {ppn, 2'b00, flags};
  endfunction

  // Drive one access on a rising edge, sample at the falling edge
  task automatic driveAccess(input logic satpMode, input privModeT priv,
                             input accessTypeT access, input logic [31:0] va,
                             input logic mxr, input logic sum);
    @(posedge clk);
    satp <= {satpMode, 31'd0};
    privMode <= priv;
    accessType <= access;
    virtualAddress <= va;
    statusMxr <= mxr;
    statusSum <= sum;
    @(negedge clk);
  endtask

  // One-cycle refill strobe as a walker would issue it
  task automatic writeEntry(input logic [31:0] va, input logic [31:0] pte, input pageTypeT pt);
    @(posedge clk);
    accessType <= 2'b00;
    virtualAddress <= va;
    pteWriteVal <= pte;
    pageTypeWriteVal <= pt;
    tlbWrite <= 1'b1;
    @(posedge clk);
    tlbWrite <= 1'b0;
  endtask

  task automatic flushTlb();
    @(posedge clk);
    tlbFlush <= 1'b1;
    @(posedge clk);
    tlbFlush <= 1'b0;
  endtask

  `include "mmuTests.svh"

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    rst = 1'b1;
    satp = '0;
    statusMxr = 1'b0;
    statusSum = 1'b0;
    privMode = machine;
    accessType = 2'b00;
    virtualAddress = '0;
    pteWriteVal = '0;
    pageTypeWriteVal = kilopage;
    tlbWrite = 1'b0;
    tlbFlush = 1'b0;
    pmpCfg = '0;
    pmpAddr = '0;
    errorCount = 0;
    testsPassed = 0;
    testsFailed = 0;
    lfsrState = 16'd93;
    repeat (4) @(posedge clk);
    rst <= 1'b0;

    // The miss test runs first on the table left empty by reset
    // PMA runs before PMP, whose locked entry would squash UART writes
    runMissRefillFlush();
    runBareMode();
    runPageFaults();
    runPmaRegions();
    runPmpEntries();

    $display("Tests passed: %0d, failed: %0d", testsPassed, testsFailed);
    if (testsFailed == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule
